// File: Makefile
TOOL     = verilator
FLAGS    = --binary --timing --assert -j 0
TOP      = tb_victim_cache
FILELIST = flist.f
OBJ_DIR  = obj_dir

.PHONY: simulate clean

simulate:
	$(TOOL) $(FLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)
	./$(OBJ_DIR)/V$(TOP)

clean:
	rm -rf $(OBJ_DIR)

// File: flist.f
victim_pkg.sv
victim_if.sv
victim_array.sv
victim_store.sv
victim_ctrl.sv
victim_cache.sv
victim_cache_sva.sv
tb_victim_cache.sv

// File: tb_victim_cache.sv
`timescale 1ns/1ps

module tb_victim_cache;
    import victim_pkg::*;

    localparam int tag_pool    = 6;
    localparam int rand_steps  = 1000;
    localparam int drain_limit = 20;

    typedef struct packed {
        logic  hit;
        line_t data;
        logic  dirty;
        logic  wb;
        addr_t wb_address;
        line_t wb_data;
    } expect_t;

    logic  clk;
    logic  rst;
    logic  lookup_valid;
    addr_t lookup_address;
    logic  evict_valid;
    addr_t evict_address;
    line_t evict_data;
    logic  evict_dirty;
    logic  resp_valid;
    logic  resp_hit;
    line_t resp_data;
    logic  resp_dirty;
    logic  wb_valid;
    addr_t wb_address;
    line_t wb_data;

    integer seed;

    // reference copy of the two ways.
    logic  ref_valid [2];
    logic  ref_dirty [2];
    tag_t  ref_tag [2];
    line_t ref_data [2];
    way_t  ref_lru;

    // expected results, oldest first.
    logic  exp_hit_q [$];
    line_t exp_data_q [$];
    logic  exp_dirty_q [$];
    addr_t exp_wb_addr_q [$];
    line_t exp_wb_data_q [$];

    logic  exp_hit;
    logic  exp_dirty;
    line_t exp_data;
    addr_t exp_wb_addr;
    line_t exp_wb_data;
    line_t line_a;

    victim_cache uut (
        .clk            (clk),
        .rst            (rst),
        .lookup_valid   (lookup_valid),
        .lookup_address (lookup_address),
        .evict_valid    (evict_valid),
        .evict_address  (evict_address),
        .evict_data     (evict_data),
        .evict_dirty    (evict_dirty),
        .resp_valid     (resp_valid),
        .resp_hit       (resp_hit),
        .resp_data      (resp_data),
        .resp_dirty     (resp_dirty),
        .wb_valid       (wb_valid),
        .wb_address     (wb_address),
        .wb_data        (wb_data)
    );

    always #5 clk = ~clk;

    // ******************************
    // reference model
    // ******************************

    function automatic expect_t model_request(input logic lv, input addr_t la, input logic ev,
                                              input addr_t ea, input line_t ed,
                                              input logic edirty);
        expect_t r;
        way_t    hw;
        way_t    fw;
        logic    swap;
        r  = '0;
        hw = 1'b0;
        fw = 1'b0;
        if (lv) begin
            for (int w = 0; w < 2; w++) begin
                if (ref_valid[w] && ref_tag[w] == la[31:5]) begin
                    r.hit = 1'b1;
                    hw    = way_t'(w);
                end
            end
        end
        swap = r.hit && ev;
        if (r.hit) begin
            r.data        = ref_data[hw];
            r.dirty       = ref_dirty[hw];
            ref_valid[hw] = 1'b0;
            ref_lru       = hw;
        end
        if (ev) begin
            if (swap) begin
                fw = hw;
            end else if (!ref_valid[0]) begin
                fw = 1'b0;
            end else if (!ref_valid[1]) begin
                fw = 1'b1;
            end else begin
                fw = ref_lru;
            end
            r.wb          = !swap && ref_valid[fw] && ref_dirty[fw];
            r.wb_address  = {ref_tag[fw], 5'b00000};
            r.wb_data     = ref_data[fw];
            ref_valid[fw] = 1'b1;
            ref_dirty[fw] = edirty;
            ref_tag[fw]   = ea[31:5];
            ref_data[fw]  = ed;
            ref_lru       = ~fw;
        end
        return r;
    endfunction

    function automatic tag_t pool_tag(input int idx);
        return tag_t'(27'h0a5c300 + idx);
    endfunction

    function automatic addr_t pool_addr(input int idx, input logic [4:0] offset);
        return {pool_tag(idx), offset};
    endfunction

    // an evict tag must not already sit in the buffer or match the lookup.
    function automatic logic tag_free(input tag_t t, input logic lv, input tag_t lt);
        return !(ref_valid[0] && ref_tag[0] == t) && !(ref_valid[1] && ref_tag[1] == t)
               && !(lv && lt == t);
    endfunction

    function automatic line_t random_line();
        line_t l;
        for (int i = 0; i < 8; i++) begin
            l[i*32 +: 32] = $random(seed);
        end
        return l;
    endfunction

    // ******************************
    // checks
    // ******************************

    task automatic fail_run();
        $display("tests failed");
        $fatal(1, "stopping at the first error");
    endtask

    task automatic check_bit(input string what, input logic got, input logic exp);
        if (got !== exp) begin
            $display("** Error at %0t ns: %s is %b, expected %b", $time, what, got, exp);
            fail_run();
        end
    endtask

    task automatic check_addr(input string what, input addr_t got, input addr_t exp);
        if (got !== exp) begin
            $display("** Error at %0t ns: %s is %h, expected %h", $time, what, got, exp);
            fail_run();
        end
    endtask

    task automatic check_line(input string what, input line_t got, input line_t exp);
        if (got !== exp) begin
            $display("** Error at %0t ns: %s is %h, expected %h", $time, what, got, exp);
            fail_run();
        end
    endtask

    always @(negedge clk) begin
        if (!rst && resp_valid) begin
            if (exp_hit_q.size() == 0) begin
                $display("resp_valid was raised at %0t ns with no lookup pending", $time);
                fail_run();
            end else begin
                exp_hit   = exp_hit_q.pop_front();
                exp_data  = exp_data_q.pop_front();
                exp_dirty = exp_dirty_q.pop_front();
                check_bit("resp_hit", resp_hit, exp_hit);
                if (exp_hit) begin
                    check_line("resp_data", resp_data, exp_data);
                    check_bit("resp_dirty", resp_dirty, exp_dirty);
                end
            end
        end
        if (!rst && wb_valid) begin
            if (exp_wb_addr_q.size() == 0) begin
                $display("wb_valid was raised at %0t ns with no write-back due", $time);
                fail_run();
            end else begin
                exp_wb_addr = exp_wb_addr_q.pop_front();
                exp_wb_data = exp_wb_data_q.pop_front();
                check_addr("wb_address", wb_address, exp_wb_addr);
                check_line("wb_data", wb_data, exp_wb_data);
            end
        end
    end

    // ******************************
    // stimulus
    // ******************************

    task automatic send(input logic lv, input addr_t la, input logic ev, input addr_t ea,
                        input line_t ed, input logic edirty);
        expect_t e;
        @(posedge clk);
        lookup_valid   <= lv;
        lookup_address <= la;
        evict_valid    <= ev;
        evict_address  <= ea;
        evict_data     <= ed;
        evict_dirty    <= edirty;
        e = model_request(lv, la, ev, ea, ed, edirty);
        if (lv) begin
            exp_hit_q.push_back(e.hit);
            exp_data_q.push_back(e.data);
            exp_dirty_q.push_back(e.dirty);
        end
        if (e.wb) begin
            exp_wb_addr_q.push_back(e.wb_address);
            exp_wb_data_q.push_back(e.wb_data);
        end
    endtask

    task automatic send_idle();
        send(1'b0, '0, 1'b0, '0, '0, 1'b0);
    endtask

    task automatic drain(input string what);
        int waited;
        waited = 0;
        send_idle();
        while ((exp_hit_q.size() != 0 || exp_wb_addr_q.size() != 0) && waited < drain_limit) begin
            @(posedge clk);
            waited++;
        end
        if (exp_hit_q.size() != 0 || exp_wb_addr_q.size() != 0) begin
            $display("timed out waiting for the %s responses and write-backs", what);
            fail_run();
        end
    endtask

    task automatic run_random();
        logic  lv;
        logic  ev;
        logic  ed;
        addr_t la;
        int    start;
        int    pick;
        int    cand;
        logic  found;
        for (int n = 0; n < rand_steps; n++) begin
            lv    = ($random(seed) & 3) != 0;
            ev    = ($random(seed) & 1) != 0;
            ed    = 1'($random(seed));
            la    = pool_addr({$random(seed)} % tag_pool, 5'($random(seed)));
            start = {$random(seed)} % tag_pool;
            pick  = 0;
            found = 1'b0;
            for (int k = tag_pool - 1; k >= 0; k--) begin
                cand = (start + k) % tag_pool;
                if (tag_free(pool_tag(cand), lv, la[31:5])) begin
                    pick  = cand;
                    found = 1'b1;
                end
            end
            send(lv, la, ev && found, pool_addr(pick, 5'($random(seed))), random_line(), ed);
        end
    endtask

    initial begin
        seed           = 32'hcab58f7a;
        clk            = 1'b0;
        rst            = 1'b1;
        lookup_valid   = 1'b0;
        lookup_address = '0;
        evict_valid    = 1'b0;
        evict_address  = '0;
        evict_data     = '0;
        evict_dirty    = 1'b0;
        for (int w = 0; w < 2; w++) begin
            ref_valid[w] = 1'b0;
            ref_dirty[w] = 1'b0;
            ref_tag[w]   = '0;
            ref_data[w]  = '0;
        end
        ref_lru = 1'b0;
        repeat (3) @(posedge clk);
        rst <= 1'b0;

        // quiet after reset, then a miss on the cleared tag value.
        repeat (4) send_idle();
        send(1'b1, 32'h0000_0004, 1'b0, '0, '0, 1'b0);
        drain("empty lookup");

        // hit returns the line and frees the entry.
        line_a = random_line();
        send(1'b0, '0, 1'b1, pool_addr(1, 5'h00), line_a, 1'b1);
        send(1'b1, pool_addr(1, 5'h1c), 1'b0, '0, '0, 1'b0);
        send(1'b1, pool_addr(1, 5'h08), 1'b0, '0, '0, 1'b0);
        drain("evict then lookup");

        // way 0, way 1, then two LRU replacements, clean and dirty.
        send(1'b0, '0, 1'b1, pool_addr(2, 5'h00), random_line(), 1'b0);
        send(1'b0, '0, 1'b1, pool_addr(3, 5'h10), random_line(), 1'b1);
        send(1'b0, '0, 1'b1, pool_addr(4, 5'h03), random_line(), 1'b1);
        send(1'b0, '0, 1'b1, pool_addr(5, 5'h1f), random_line(), 1'b0);
        drain("replacement");

        // swap of a dirty hit line with a clean evict.
        send(1'b1, pool_addr(4, 5'h10), 1'b1, pool_addr(0, 5'h00), random_line(), 1'b0);
        send(1'b1, pool_addr(0, 5'h02), 1'b0, '0, '0, 1'b0);
        send(1'b1, pool_addr(5, 5'h00), 1'b0, '0, '0, 1'b0);
        drain("swap");

        run_random();
        drain("random traffic");

        $display("all tests passed");
        $finish;
    end

endmodule : tb_victim_cache

// File: victim_array.sv
`timescale 1ns/1ps

module victim_array #(
    parameter int width = 1
) (
    input  logic             clk,
    input  logic             rst,
    input  logic             load,
    input  logic [width-1:0] datain,
    output logic [width-1:0] dataout
);

    logic [width-1:0] data_q;

    // holds its value until the next load.
    always_ff @(posedge clk) begin
        if (rst) begin
            data_q <= '0;
        end else if (load) begin
            data_q <= datain;
        end
    end

    assign dataout = data_q;

endmodule : victim_array

// File: victim_cache.sv
`timescale 1ns/1ps

module victim_cache (
    input  logic              clk,
    input  logic              rst,

    // lookup from the L1 controller.
    input  logic              lookup_valid,
    input  victim_pkg::addr_t lookup_address,

    // evicted line from L1.
    input  logic              evict_valid,
    input  victim_pkg::addr_t evict_address,
    input  victim_pkg::line_t evict_data,
    input  logic              evict_dirty,

    // lookup response.
    output logic              resp_valid,
    output logic              resp_hit,
    output victim_pkg::line_t resp_data,
    output logic              resp_dirty,

    // write-back to memory.
    output logic              wb_valid,
    output victim_pkg::addr_t wb_address,
    output victim_pkg::line_t wb_data
);

    victim_if bus ();

    victim_store u_store (
        .clk            (clk),
        .rst            (rst),
        .lookup_address (lookup_address),
        .evict_address  (evict_address),
        .evict_data     (evict_data),
        .bus            (bus.store)
    );

    victim_ctrl u_ctrl (
        .clk          (clk),
        .rst          (rst),
        .lookup_valid (lookup_valid),
        .evict_valid  (evict_valid),
        .evict_dirty  (evict_dirty),
        .resp_valid   (resp_valid),
        .resp_hit     (resp_hit),
        .resp_data    (resp_data),
        .resp_dirty   (resp_dirty),
        .wb_valid     (wb_valid),
        .wb_address   (wb_address),
        .wb_data      (wb_data),
        .bus          (bus.ctrl)
    );

endmodule : victim_cache

// File: victim_cache_sva.sv
`timescale 1ns/1ps

module victim_cache_sva (
    input logic clk,
    input logic rst,
    input logic lookup_valid,
    input logic evict_valid,
    input logic resp_valid,
    input logic resp_hit,
    input logic wb_valid
);

    // one response per lookup, one cycle later.
    resp_follows_lookup: assert property (
        @(posedge clk) disable iff (rst)
        !$past(rst) |-> (resp_valid == $past(lookup_valid))
    ) else $error("resp_valid did not follow lookup_valid by one cycle");

    wb_after_evict: assert property (
        @(posedge clk) disable iff (rst)
        wb_valid |-> ($past(evict_valid) && !$past(rst))
    ) else $error("wb_valid without an evict in the previous cycle");

    hit_needs_resp: assert property (
        @(posedge clk) disable iff (rst)
        resp_hit |-> resp_valid
    ) else $error("resp_hit raised without resp_valid");

    // outputs cleared by the reset edge.
    quiet_in_reset: assert property (
        @(posedge clk)
        $past(rst) |-> (!resp_valid && !resp_hit && !wb_valid)
    ) else $error("outputs not low during reset");

endmodule : victim_cache_sva

bind victim_cache victim_cache_sva u_sva (
    .clk          (clk),
    .rst          (rst),
    .lookup_valid (lookup_valid),
    .evict_valid  (evict_valid),
    .resp_valid   (resp_valid),
    .resp_hit     (resp_hit),
    .wb_valid     (wb_valid)
);

// File: victim_ctrl.sv
`timescale 1ns/1ps

module victim_ctrl (
    input  logic              clk,
    input  logic              rst,
    input  logic              lookup_valid,
    input  logic              evict_valid,
    input  logic              evict_dirty,
    output logic              resp_valid,
    output logic              resp_hit,
    output victim_pkg::line_t resp_data,
    output logic              resp_dirty,
    output logic              wb_valid,
    output victim_pkg::addr_t wb_address,
    output victim_pkg::line_t wb_data,
    victim_if.ctrl            bus
);
    import victim_pkg::*;

    logic lookup_hit;
    logic swap;
    logic wb_due;
    way_t fill_way;

    assign lookup_hit = lookup_valid & bus.hit;

    // hit and evict together swap the lines.
    assign swap = lookup_hit & evict_valid;

    // ******************************
    // fill way choice
    // ******************************

    always_comb begin
        if (swap) begin
            fill_way = bus.way_hit;
        end else if (!bus.valid_out[0]) begin
            fill_way = 1'b0;
        end else if (!bus.valid_out[1]) begin
            fill_way = 1'b1;
        end else begin
            fill_way = bus.lru;
        end
    end

    assign bus.victim_way = fill_way;

    // a valid dirty line pushed out by a plain fill.
    assign wb_due = evict_valid & ~swap
                  & bus.valid_out[fill_way] & bus.dirty_out[fill_way];

    // ******************************
    // load strobes
    // ******************************

    always_comb begin
        bus.ld_valid = '0;
        bus.ld_dirty = '0;
        bus.ld_tag   = '0;
        bus.ld_data  = '0;
        bus.ld_lru   = 1'b0;
        bus.valid_in = 1'b0;
        bus.dirty_in = 1'b0;
        bus.lru_in   = 1'b0;

        if (evict_valid) begin
            // fill, which also covers the swap case.
            bus.ld_valid[fill_way] = 1'b1;
            bus.ld_dirty[fill_way] = 1'b1;
            bus.ld_tag[fill_way]   = 1'b1;
            bus.ld_data[fill_way]  = 1'b1;
            bus.ld_lru             = 1'b1;
            bus.valid_in           = 1'b1;
            bus.dirty_in           = evict_dirty;
            bus.lru_in             = ~fill_way;
        end else if (lookup_hit) begin
            // line returns to L1, so free its way.
            bus.ld_valid[bus.way_hit] = 1'b1;
            bus.ld_lru                = 1'b1;
            bus.lru_in                = bus.way_hit;
        end
    end

    // ******************************
    // registered outputs
    // ******************************

    always_ff @(posedge clk) begin
        if (rst) begin
            resp_valid <= 1'b0;
            resp_hit   <= 1'b0;
            wb_valid   <= 1'b0;
        end else begin
            resp_valid <= lookup_valid;
            resp_hit   <= lookup_hit;
            wb_valid   <= wb_due;
        end
    end

    always_ff @(posedge clk) begin
        if (lookup_hit) begin
            resp_data  <= bus.hit_data;
            resp_dirty <= bus.hit_dirty;
        end
        if (wb_due) begin
            wb_address <= {bus.wb_tag, {offset_bits{1'b0}}};
            wb_data    <= bus.wb_line;
        end
    end

endmodule : victim_ctrl

// File: victim_if.sv
`timescale 1ns/1ps

interface victim_if;
    import victim_pkg::*;

    // load strobes, one bit per way.
    logic [way_count-1:0] ld_valid;
    logic [way_count-1:0] ld_dirty;
    logic [way_count-1:0] ld_tag;
    logic [way_count-1:0] ld_data;
    logic                 ld_lru;

    // values written under the strobes.
    logic valid_in;
    logic dirty_in;
    way_t lru_in;

    // way picked for the fill.
    way_t victim_way;

    // lookup result.
    logic  hit;
    way_t  way_hit;
    line_t hit_data;
    logic  hit_dirty;

    // per-way status.
    logic [way_count-1:0] valid_out;
    logic [way_count-1:0] dirty_out;
    way_t                 lru;

    // contents of victim_way.
    tag_t  wb_tag;
    line_t wb_line;

    modport ctrl (
        output ld_valid, ld_dirty, ld_tag, ld_data, ld_lru,
        output valid_in, dirty_in, lru_in, victim_way,
        input  hit, way_hit, hit_data, hit_dirty,
        input  valid_out, dirty_out, lru, wb_tag, wb_line
    );

    modport store (
        input  ld_valid, ld_dirty, ld_tag, ld_data, ld_lru,
        input  valid_in, dirty_in, lru_in, victim_way,
        output hit, way_hit, hit_data, hit_dirty,
        output valid_out, dirty_out, lru, wb_tag, wb_line
    );

endinterface : victim_if

// File: victim_pkg.sv
package victim_pkg;

    // ******************************
    // widths
    // ******************************

    localparam int unsigned addr_width = 32;
    localparam int unsigned line_width = 256;

    // byte offset inside a 32-byte line.
    localparam int unsigned offset_bits = 5;

    // line address without its byte offset.
    localparam int unsigned tag_width = addr_width - offset_bits;

    // ******************************
    // types
    // ******************************

    typedef logic [addr_width-1:0] addr_t;
    typedef logic [line_width-1:0] line_t;
    typedef logic [tag_width-1:0]  tag_t;

    // one bit picks one of the two ways.
    typedef logic way_t;

    localparam int unsigned way_count = 1 << $bits(way_t);

endpackage : victim_pkg

// File: victim_store.sv
`timescale 1ns/1ps

module victim_store (
    input  logic              clk,
    input  logic              rst,
    input  victim_pkg::addr_t lookup_address,
    input  victim_pkg::addr_t evict_address,
    input  victim_pkg::line_t evict_data,
    victim_if.store           bus
);
    import victim_pkg::*;

    logic [way_count-1:0] valid_q;
    logic [way_count-1:0] dirty_q;
    logic [way_count-1:0] match;
    way_t                 lru_q;
    tag_t                 tag_q [way_count];
    line_t                data_q [way_count];
    tag_t                 lookup_tag;
    tag_t                 evict_tag;

    assign lookup_tag = lookup_address[addr_width-1:offset_bits];
    assign evict_tag  = evict_address[addr_width-1:offset_bits];

    // ******************************
    // storage
    // ******************************

    for (genvar w = 0; w < way_count; w++) begin : g_way
        victim_array #(.width(1)) valid_arr (
            .clk     (clk),
            .rst     (rst),
            .load    (bus.ld_valid[w]),
            .datain  (bus.valid_in),
            .dataout (valid_q[w])
        );

        victim_array #(.width(1)) dirty_arr (
            .clk     (clk),
            .rst     (rst),
            .load    (bus.ld_dirty[w]),
            .datain  (bus.dirty_in),
            .dataout (dirty_q[w])
        );

        victim_array #(.width(tag_width)) tag_arr (
            .clk     (clk),
            .rst     (rst),
            .load    (bus.ld_tag[w]),
            .datain  (evict_tag),
            .dataout (tag_q[w])
        );

        victim_array #(.width(line_width)) data_arr (
            .clk     (clk),
            .rst     (rst),
            .load    (bus.ld_data[w]),
            .datain  (evict_data),
            .dataout (data_q[w])
        );

        // only a valid way can hit.
        assign match[w] = valid_q[w] && (tag_q[w] == lookup_tag);
    end

    victim_array #(.width(1)) lru_arr (
        .clk     (clk),
        .rst     (rst),
        .load    (bus.ld_lru),
        .datain  (bus.lru_in),
        .dataout (lru_q)
    );

    // ******************************
    // lookup and status
    // ******************************

    always_comb begin
        bus.hit     = |match;
        // tags never repeat across ways, so one match at most.
        bus.way_hit = match[1];
    end

    assign bus.hit_data  = data_q[bus.way_hit];
    assign bus.hit_dirty = dirty_q[bus.way_hit];

    assign bus.valid_out = valid_q;
    assign bus.dirty_out = dirty_q;
    assign bus.lru       = lru_q;

    // contents of the way about to be filled.
    assign bus.wb_tag  = tag_q[bus.victim_way];
    assign bus.wb_line = data_q[bus.victim_way];

endmodule : victim_store
